// ==== src/lvdc_pkg.sv ====
`default_nettype none

package lvdc_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int OPCODE_W = 4;  // operation code.
    localparam int ADDR_W   = 9;  // operand address, top bit doubles as HOP module bit.
    localparam int PHASE_W  = 3;  // phase count.
    localparam int BT_W     = 5;  // bit-time count.

    // seven phase clocks make one bit time.
    localparam int PHASES = 7;

    //////////////////////////////
    // opcodes
    //////////////////////////////

    // module transfer, no memory access.
    localparam logic [OPCODE_W-1:0] OP_HOP = 4'b0000;

    // store, write replaces the read.
    localparam logic [OPCODE_W-1:0] OP_STO = 4'b1011;

endpackage

`default_nettype wire

// ==== src/timing_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface timing_if;

    logic [lvdc_pkg::PHASE_W-1:0] phase;     // 0 .. PHASES-1.
    logic [lvdc_pkg::BT_W-1:0]    bit_time;  // 0 .. BIT_TIMES-1.
    logic                         word_start;
    logic                         word_end;

    // phase generator side.
    modport source (
        output phase,
        output bit_time,
        output word_start,
        output word_end
    );

    // users of the word timing.
    modport sink (
        input phase,
        input bit_time,
        input word_start,
        input word_end
    );

endinterface

`default_nettype wire

// ==== src/phase_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_clock #(
    parameter int BIT_TIMES = 14
) (
    input  wire      sim_clk,
    input  wire      arst_n,
    timing_if.source tim
);

    localparam logic [lvdc_pkg::PHASE_W-1:0] LAST_PHASE =
        lvdc_pkg::PHASE_W'(lvdc_pkg::PHASES - 1);
    localparam logic [lvdc_pkg::BT_W-1:0] LAST_BT =
        lvdc_pkg::BT_W'(BIT_TIMES - 1);

    logic [lvdc_pkg::PHASE_W-1:0] phase_cnt;
    logic [lvdc_pkg::BT_W-1:0]    bt_cnt;

    //////////////////////////////
    // counters
    //////////////////////////////

    // bit time steps on the phase wrap.
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_cnt <= '0;
            bt_cnt    <= '0;
        end else if (phase_cnt == LAST_PHASE) begin
            phase_cnt <= '0;
            if (bt_cnt == LAST_BT) begin
                bt_cnt <= '0;  // new word.
            end else begin
                bt_cnt <= bt_cnt + 1'b1;
            end
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // word strobes
    //////////////////////////////

    assign tim.phase    = phase_cnt;
    assign tim.bit_time = bt_cnt;

    // counts sit at zero out of reset, so the first cycle is a word start.
    assign tim.word_start = (phase_cnt == '0) && (bt_cnt == '0);
    assign tim.word_end   = (phase_cnt == LAST_PHASE) && (bt_cnt == LAST_BT);

endmodule

`default_nettype wire

// ==== src/cycle_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cycle_control (
    input  wire                          sim_clk,
    input  wire                          arst_n,
    input  wire                          start,
    input  wire                          halt,
    input  wire [lvdc_pkg::OPCODE_W-1:0] op_code,
    input  wire [lvdc_pkg::ADDR_W-1:0]   operand,
    timing_if.sink                       tim,
    output logic                         run,
    output logic                         rd_req,
    output logic                         wr_req,
    output logic [lvdc_pkg::ADDR_W-1:0]  op_addr
);

    logic capture;
    logic is_hop;
    logic is_sto;

    //////////////////////////////
    // run / halt
    //////////////////////////////

    // decided at word end, halt wins over start.
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
        end else if (tim.word_end) begin
            if (halt) begin
                run <= 1'b0;
            end else if (start) begin
                run <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // operation capture
    //////////////////////////////

    assign capture = tim.word_start && run;
    assign is_hop  = (op_code == lvdc_pkg::OP_HOP);
    assign is_sto  = (op_code == lvdc_pkg::OP_STO);

    // one-cycle requests; a store inhibits the read, a HOP asks for nothing.
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_req <= 1'b0;
            wr_req <= 1'b0;
        end else begin
            rd_req <= capture && !is_hop && !is_sto;
            wr_req <= capture && is_sto;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (capture) begin
            op_addr <= operand;  // held for the sequencer.
        end
    end

endmodule

`default_nettype wire

// ==== src/module_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module module_select (
    input  wire                          sim_clk,
    input  wire                          arst_n,
    input  wire                          run,
    input  wire [lvdc_pkg::OPCODE_W-1:0] op_code,
    input  wire [lvdc_pkg::ADDR_W-1:0]   operand,
    timing_if.sink                       tim,
    output logic                         sel_b
);

    logic hop_load;

    // a HOP taken at word start while running.
    assign hop_load = tim.word_start && run && (op_code == lvdc_pkg::OP_HOP);

    //////////////////////////////
    // current module
    //////////////////////////////

    // 0 selects module A, 1 selects module B.
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_b <= 1'b0;
        end else if (hop_load) begin
            sel_b <= operand[lvdc_pkg::ADDR_W-1];  // bit 8 names the module.
        end
    end

endmodule

`default_nettype wire

// ==== src/memory_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_sequencer (
    input  wire                         sim_clk,
    input  wire                         arst_n,
    input  wire                         rd_req,
    input  wire                         wr_req,
    input  wire                         sel_b,
    input  wire  [lvdc_pkg::ADDR_W-1:0] op_addr,
    output logic                        mem_rd_a,
    output logic                        mem_rd_b,
    output logic                        mem_wr_a,
    output logic                        mem_wr_b,
    output logic [lvdc_pkg::ADDR_W-1:0] mem_addr
);

    logic any_req;

    assign any_req = rd_req || wr_req;

    //////////////////////////////
    // module strobes
    //////////////////////////////

    // the request is steered to one module, at most one strobe per word.
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_rd_a <= 1'b0;
            mem_rd_b <= 1'b0;
            mem_wr_a <= 1'b0;
            mem_wr_b <= 1'b0;
        end else begin
            mem_rd_a <= rd_req && !sel_b;
            mem_rd_b <= rd_req && sel_b;
            mem_wr_a <= wr_req && !sel_b;
            mem_wr_b <= wr_req && sel_b;
        end
    end

    //////////////////////////////
    // address
    //////////////////////////////

    // last issued address, held between accesses.
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_addr <= '0;
        end else if (any_req) begin
            mem_addr <= op_addr;
        end
    end

endmodule

`default_nettype wire

// ==== src/lvdc_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lvdc_mem_top #(
    parameter int BIT_TIMES = 14
) (
    input  wire                          sim_clk,
    input  wire                          arst_n,
    input  wire                          start,
    input  wire                          halt,
    input  wire [lvdc_pkg::OPCODE_W-1:0] op_code,
    input  wire [lvdc_pkg::ADDR_W-1:0]   operand,
    output wire                          run,
    output wire                          mem_rd_a,
    output wire                          mem_rd_b,
    output wire                          mem_wr_a,
    output wire                          mem_wr_b,
    output wire [lvdc_pkg::ADDR_W-1:0]   mem_addr,
    output wire                          word_start
);

    wire                        rd_req;
    wire                        wr_req;
    wire                        sel_b;
    wire [lvdc_pkg::ADDR_W-1:0] op_addr;

    timing_if tim ();

    assign word_start = tim.word_start;  // framing for the testbench.

    //////////////////////////////
    // timing
    //////////////////////////////

    phase_clock #(
        .BIT_TIMES (BIT_TIMES)
    ) u_phase_clock (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .tim     (tim.source)
    );

    //////////////////////////////
    // control
    //////////////////////////////

    cycle_control u_cycle_control (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .start   (start),
        .halt    (halt),
        .op_code (op_code),
        .operand (operand),
        .tim     (tim.sink),
        .run     (run),
        .rd_req  (rd_req),
        .wr_req  (wr_req),
        .op_addr (op_addr)
    );

    module_select u_module_select (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .run     (run),
        .op_code (op_code),
        .operand (operand),
        .tim     (tim.sink),
        .sel_b   (sel_b)
    );

    memory_sequencer u_memory_sequencer (
        .sim_clk  (sim_clk),
        .arst_n   (arst_n),
        .rd_req   (rd_req),
        .wr_req   (wr_req),
        .sel_b    (sel_b),
        .op_addr  (op_addr),
        .mem_rd_a (mem_rd_a),
        .mem_rd_b (mem_rd_b),
        .mem_wr_a (mem_wr_a),
        .mem_wr_b (mem_wr_b),
        .mem_addr (mem_addr)
    );

endmodule

`default_nettype wire

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic sim_clk,
    output logic arst_n
);

    initial begin
        sim_clk = 1'b0;
        forever #(PERIOD_NS / 2) sim_clk = ~sim_clk;
    end

    // released just after a rising edge, so the first word starts cleanly.
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sim_clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_checker #(
    parameter int BIT_TIMES = 14
) (
    input  wire                          sim_clk,
    input  wire                          arst_n,
    input  wire                          start,
    input  wire                          halt,
    input  wire [lvdc_pkg::OPCODE_W-1:0] op_code,
    input  wire [lvdc_pkg::ADDR_W-1:0]   operand,
    input  wire                          run,
    input  wire [3:0]                    strobes,  // {rd_a, rd_b, wr_a, wr_b}.
    input  wire [lvdc_pkg::ADDR_W-1:0]   mem_addr,
    input  wire                          word_start,
    output int                           errors,
    output int                           n_rd_a,
    output int                           n_rd_b,
    output int                           n_wr_a,
    output int                           n_wr_b
);

    localparam int WORD_LEN = lvdc_pkg::PHASES * BIT_TIMES;

    int                        cyc;
    logic                      run_m;
    logic                      mod_b;
    logic [1:0]                kind;
    logic                      on_b;
    logic [3:0]                want;
    logic [lvdc_pkg::ADDR_W-1:0] want_addr;
    logic [lvdc_pkg::ADDR_W-1:0] last_addr;

    // kind 0 is no access, 1 a read, 2 a write.
    function automatic void expected_access(
        input  logic [lvdc_pkg::OPCODE_W-1:0] op,
        input  logic [lvdc_pkg::ADDR_W-1:0]   opnd,
        input  logic                          module_b,
        output logic [1:0]                    acc_kind,
        output logic                          acc_b,
        output logic [lvdc_pkg::ADDR_W-1:0]   acc_addr
    );
        acc_kind = 2'd1;
        if (op == lvdc_pkg::OP_HOP)
            acc_kind = 2'd0;
        else if (op == lvdc_pkg::OP_STO)
            acc_kind = 2'd2;
        acc_b    = module_b;
        acc_addr = opnd;
    endfunction

    //////////////////////////////
    // compare on the falling edge
    //////////////////////////////

    always @(negedge sim_clk) begin
        if (!arst_n) begin
            cyc       = 0;
            run_m     = 1'b0;
            mod_b     = 1'b0;
            want      = 4'b0000;
            last_addr = '0;
            errors    = 0;
            n_rd_a    = 0;
            n_rd_b    = 0;
            n_wr_a    = 0;
            n_wr_b    = 0;
        end else begin
            if (word_start !== (cyc == 0)) begin
                $display("** Error at %0t: word_start is %b in cycle %0d", $time, word_start, cyc);
                errors++;
            end
            if (run !== run_m) begin
                $display("** Error at %0t: run is %b, expected %b", $time, run, run_m);
                errors++;
            end
            n_rd_a += strobes[3];
            n_rd_b += strobes[2];
            n_wr_a += strobes[1];
            n_wr_b += strobes[0];
            if (cyc == 2 && want != 4'b0000) begin
                if (strobes === 4'b0000) begin
                    $display("missing memory strobe at %0t, wanted %b", $time, want);
                    errors++;
                end else if (strobes !== want) begin
                    $display("** Error at %0t: strobes %b, expected %b", $time, strobes, want);
                    errors++;
                end
                last_addr = want_addr;  // address moves with the access.
            end else if (strobes !== 4'b0000) begin
                $display("unexpected memory strobe %b at %0t in cycle %0d", strobes, $time, cyc);
                errors++;
            end
            if (mem_addr !== last_addr) begin
                $display("** Error at %0t: mem_addr %h, expected %h", $time, mem_addr, last_addr);
                errors++;
            end

            // reference model steps to the next cycle.
            if (cyc == 0) begin
                want = 4'b0000;
                if (run_m) begin
                    expected_access(op_code, operand, mod_b, kind, on_b, want_addr);
                    case (kind)
                        2'd1:    want = on_b ? 4'b0100 : 4'b1000;
                        2'd2:    want = on_b ? 4'b0001 : 4'b0010;
                        default: want = 4'b0000;
                    endcase
                    if (op_code == lvdc_pkg::OP_HOP)
                        mod_b = operand[lvdc_pkg::ADDR_W-1];
                end
            end
            if (cyc == WORD_LEN - 1) begin
                if (halt)
                    run_m = 1'b0;
                else if (start)
                    run_m = 1'b1;
            end
            cyc = (cyc == WORD_LEN - 1) ? 0 : cyc + 1;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_lvdc_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lvdc_mem;

    localparam int BIT_TIMES = 14;
    localparam int TIMEOUT   = 4 * lvdc_pkg::PHASES * BIT_TIMES;  // four words.

    wire                           sim_clk;
    wire                           arst_n;
    logic                          start;
    logic                          halt;
    logic [lvdc_pkg::OPCODE_W-1:0] op_code;
    logic [lvdc_pkg::ADDR_W-1:0]   operand;
    wire                           run;
    wire                           mem_rd_a, mem_rd_b, mem_wr_a, mem_wr_b;
    wire [lvdc_pkg::ADDR_W-1:0]    mem_addr;
    wire                           word_start;
    wire [31:0]                    chk_errors;
    wire [31:0]                    n_rd_a, n_rd_b, n_wr_a, n_wr_b;

    integer seed;
    int     tb_errors;
    int     base_errors;
    int     tests;
    int     failed;
    int     s_rd_a, s_rd_b, s_wr_a, s_wr_b;

    clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(16)) u_clk_gen (
        .sim_clk (sim_clk),
        .arst_n  (arst_n)
    );

    lvdc_mem_top #(.BIT_TIMES(BIT_TIMES)) UUT (
        .sim_clk (sim_clk), .arst_n (arst_n), .start (start), .halt (halt),
        .op_code (op_code), .operand (operand), .run (run),
        .mem_rd_a (mem_rd_a), .mem_rd_b (mem_rd_b), .mem_wr_a (mem_wr_a),
        .mem_wr_b (mem_wr_b), .mem_addr (mem_addr), .word_start (word_start)
    );

    mem_checker #(.BIT_TIMES(BIT_TIMES)) u_checker (
        .sim_clk (sim_clk), .arst_n (arst_n), .start (start), .halt (halt),
        .op_code (op_code), .operand (operand), .run (run),
        .strobes ({mem_rd_a, mem_rd_b, mem_wr_a, mem_wr_b}),
        .mem_addr (mem_addr), .word_start (word_start), .errors (chk_errors),
        .n_rd_a (n_rd_a), .n_rd_b (n_rd_b), .n_wr_a (n_wr_a), .n_wr_b (n_wr_b)
    );

    //////////////////////////////
    // stimulus tasks
    //////////////////////////////

    // new inputs go in right after a word start and are captured at the next one.
    task automatic drive_word(input logic s, input logic h,
                              input logic [lvdc_pkg::OPCODE_W-1:0] op,
                              input logic [lvdc_pkg::ADDR_W-1:0] opnd);
        int n;
        n = 0;
        @(negedge sim_clk);
        while (!word_start && n < TIMEOUT) begin
            @(negedge sim_clk);
            n++;
        end
        if (!word_start) begin
            $display("timeout at %0t: no word start within four words", $time);
            tb_errors++;
        end
        @(posedge sim_clk);
        start   <= s;
        halt    <= h;
        op_code <= op;
        operand <= opnd;
        repeat (3) @(negedge sim_clk);  // past the strobe slot of this word.
    endtask

    task automatic wait_run(input logic level);
        int n;
        n = 0;
        while (run !== level && n < TIMEOUT) begin
            @(negedge sim_clk);
            n++;
        end
        if (run !== level) begin
            $display("timeout at %0t: run never went to %b", $time, level);
            tb_errors++;
        end else if (!word_start) begin
            $display("** Error at %0t: run went to %b outside a word start", $time, level);
            tb_errors++;
        end
    endtask

    task automatic take_snapshot();
        s_rd_a = n_rd_a;
        s_rd_b = n_rd_b;
        s_wr_a = n_wr_a;
        s_wr_b = n_wr_b;
    endtask

    // strobe counts since the last snapshot.
    task automatic expect_strobes(input int ra, input int rb, input int wa, input int wb);
        @(posedge sim_clk);  // counts settle on the falling edge.
        if (n_rd_a - s_rd_a != ra || n_rd_b - s_rd_b != rb ||
            n_wr_a - s_wr_a != wa || n_wr_b - s_wr_b != wb) begin
            $display("** Error at %0t: strobe counts %0d %0d %0d %0d, expected %0d %0d %0d %0d",
                     $time, n_rd_a - s_rd_a, n_rd_b - s_rd_b, n_wr_a - s_wr_a,
                     n_wr_b - s_wr_b, ra, rb, wa, wb);
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        @(posedge sim_clk);
        errs = chk_errors + tb_errors - base_errors;
        tests++;
        if (errs != 0)
            failed++;
        $display("test %0d %s: %s, %0d errors", tests, name, (errs == 0) ? "pass" : "fail", errs);
        base_errors = chk_errors + tb_errors;
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    initial begin
        int          i;
        int          n;
        logic [31:0] r;
        seed        = 32'hb2cc66f0;
        start       = 1'b0;
        halt        = 1'b0;
        op_code     = '0;
        operand     = '0;
        tb_errors   = 0;
        base_errors = 0;
        tests       = 0;
        failed      = 0;
        n           = 0;
        while (arst_n !== 1'b1 && n < 64) begin
            @(negedge sim_clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            $display("timeout at %0t: reset was never released", $time);
            tb_errors++;
        end

        // a read opcode, so a stray run would show up as a strobe.
        take_snapshot();
        repeat (3) drive_word(1'b0, 1'b0, 4'h1, 9'h011);
        expect_strobes(0, 0, 0, 0);
        end_test("idle after reset");

        take_snapshot();
        drive_word(1'b1, 1'b0, 4'h1, 9'h055);
        wait_run(1'b1);
        drive_word(1'b1, 1'b1, lvdc_pkg::OP_HOP, 9'h000);
        wait_run(1'b0);
        expect_strobes(2, 0, 0, 0);
        take_snapshot();
        repeat (2) drive_word(1'b0, 1'b0, 4'h1, 9'h033);
        expect_strobes(0, 0, 0, 0);
        end_test("start and halt");

        // each group ends on a HOP to module A, which gives no strobe.
        take_snapshot();
        drive_word(1'b1, 1'b0, 4'h1, 9'h021);
        drive_word(1'b1, 1'b0, lvdc_pkg::OP_HOP, 9'h100);
        drive_word(1'b1, 1'b0, 4'h6, 9'h0a3);
        drive_word(1'b1, 1'b0, lvdc_pkg::OP_HOP, 9'h000);
        expect_strobes(1, 1, 0, 0);
        end_test("read on current module");

        take_snapshot();
        drive_word(1'b1, 1'b0, lvdc_pkg::OP_STO, 9'h1f0);
        drive_word(1'b1, 1'b0, lvdc_pkg::OP_HOP, 9'h100);
        drive_word(1'b1, 1'b0, lvdc_pkg::OP_STO, 9'h00f);
        drive_word(1'b1, 1'b0, lvdc_pkg::OP_HOP, 9'h000);
        expect_strobes(0, 0, 1, 1);
        end_test("store gives a write");

        take_snapshot();
        drive_word(1'b1, 1'b0, lvdc_pkg::OP_HOP, 9'h1ff);
        drive_word(1'b1, 1'b0, 4'h3, 9'h044);
        drive_word(1'b1, 1'b0, lvdc_pkg::OP_HOP, 9'h0ff);
        drive_word(1'b1, 1'b0, 4'h3, 9'h145);
        drive_word(1'b1, 1'b0, lvdc_pkg::OP_HOP, 9'h000);
        expect_strobes(1, 1, 0, 0);
        end_test("hop switches module");

        for (i = 0; i < 200; i++) begin
            r = $random(seed);
            case (r[6:5])  // bias toward HOP and STO.
                2'd0:    drive_word(r[0] | r[1], r[4:2] == 3'b000, lvdc_pkg::OP_HOP, r[19:11]);
                2'd1:    drive_word(r[0] | r[1], r[4:2] == 3'b000, lvdc_pkg::OP_STO, r[19:11]);
                default: drive_word(r[0] | r[1], r[4:2] == 3'b000, r[10:7], r[19:11]);
            endcase
        end
        drive_word(1'b0, 1'b1, lvdc_pkg::OP_HOP, 9'h000);
        end_test("random words");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests, tests - failed, failed, chk_errors + tb_errors);
        if (failed == 0 && chk_errors + tb_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
src/lvdc_pkg.sv
src/timing_if.sv
src/phase_clock.sv
src/cycle_control.sv
src/module_select.sv
src/memory_sequencer.sv
src/lvdc_mem_top.sv
verif/clk_gen.sv
verif/mem_checker.sv
verif/tb_lvdc_mem.sv

// ==== Bender.yml ====
package:
  name: lvdc_mem

sources:
  - src/lvdc_pkg.sv
  - src/timing_if.sv
  - src/phase_clock.sv
  - src/cycle_control.sv
  - src/module_select.sv
  - src/memory_sequencer.sv
  - src/lvdc_mem_top.sv
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/mem_checker.sv
      - verif/tb_lvdc_mem.sv
